/* design/anneal_cfg.svh */
`ifndef ANNEAL_CFG_SVH
`define ANNEAL_CFG_SVH

// Number of spins carried by one candidate vector
`define NUM_SPIN 16

// Signed width of one field weight in the weight table
`define WEIGHT_BIT 8

// Signed width of a candidate energy that holds the sum of NUM_SPIN weights
`define ENERGY_BIT 16

// Entries in the energy FIFO that holds the running best
`define ENERGY_FIFO_DEPTH 2

// Largest positive energy that the FIFO is loaded with on reset and on flush
`define ENERGY_INIT ({1'b0, {(`ENERGY_BIT-1){1'b1}}})

// Width of the saturating improvement counter
`define COUNT_BIT 8

`endif

/* design/anneal_pkg.sv */
package anneal_pkg;

`include "anneal_cfg.svh"

    // One candidate spin vector where bit i is the state of spin i
    typedef logic [`NUM_SPIN-1:0] spin_t;

    // Signed energy of a full candidate
    typedef logic signed [`ENERGY_BIT-1:0] energy_t;

    // Signed field weight of a single spin
    typedef logic signed [`WEIGHT_BIT-1:0] weight_t;

    // Index into the weight table
    typedef logic [$clog2(`NUM_SPIN)-1:0] spin_addr_t;

    // FIFO occupancy from 0 up to the FIFO depth of 2
    typedef logic [1:0] usage_t;

    // Improvement counter value
    typedef logic [`COUNT_BIT-1:0] count_t;

    // Input stage state where HOLD keeps a computed candidate until it is taken
    typedef enum logic {
        CALC_IDLE,
        CALC_HOLD
    } calc_state_t;

endpackage

/* design/energy_fifo.sv */
`timescale 1ns/1ns

`include "anneal_cfg.svh"

module energy_fifo
    import anneal_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    flush_i,
    input  logic    push_i,
    input  logic    push_none_i,
    input  logic    pop_i,
    input  energy_t data_i,
    output logic    full_o,
    output energy_t data_o,
    output usage_t  usage_o
);

    localparam int DEPTH = `ENERGY_FIFO_DEPTH;
    localparam int PTR_BIT = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_BIT-1:0] ptr_t;

    localparam ptr_t LAST_PTR = ptr_t'(DEPTH - 1);

    energy_t mem_q [DEPTH];
    ptr_t    rd_ptr_q;
    ptr_t    wr_ptr_q;
    usage_t  usage_q;
    logic    do_push;
    logic    do_pop;
    energy_t push_data;

    // Pointers wrap at the last entry so any depth works, not only powers of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == LAST_PTR) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // A pop frees a slot in the same cycle, so a full FIFO may still take a push then
    assign do_pop  = pop_i & (usage_q != '0);
    assign do_push = push_i & (~full_o | do_pop);

    // Without an improvement the head is duplicated, so the head stays the minimum
    assign push_data = push_none_i ? mem_q[rd_ptr_q] : data_i;

    assign full_o  = (usage_q == usage_t'(DEPTH));
    assign data_o  = mem_q[rd_ptr_q];
    assign usage_o = usage_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= `ENERGY_INIT;
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= next_ptr('0);
            usage_q  <= usage_t'(1);
        end else if (flush_i) begin
            // Flush returns to the single seed entry, just like reset
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= `ENERGY_INIT;
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= next_ptr('0);
            usage_q  <= usage_t'(1);
        end else begin
            if (do_push) begin
                mem_q[wr_ptr_q] <= push_data;
                wr_ptr_q        <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Occupancy only moves when exactly one side is active
            if (do_push && !do_pop) begin
                usage_q <= usage_q + 1'b1;
            end else if (!do_push && do_pop) begin
                usage_q <= usage_q - 1'b1;
            end
        end
    end

endmodule

/* design/spin_pipe.sv */
`timescale 1ns/1ns

module spin_pipe
    import anneal_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  valid_i,
    input  spin_t data_i,
    input  logic  ready_i,
    output logic  ready_o,
    output logic  valid_o,
    output spin_t data_o
);

    logic  valid_q;
    spin_t data_q;

    // The slot can load when it is empty or when its entry leaves this cycle
    assign ready_o = ~valid_q | ready_i;

    assign valid_o = valid_q;
    assign data_o  = data_q;

    // Valid flag of the single slot
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            // A drained slot without new input goes empty
            valid_q <= valid_i;
        end
    end

    // Payload only changes on an upstream transfer
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

endmodule

/* design/spin_energy_calc.sv */
`timescale 1ns/1ns

`include "anneal_cfg.svh"

module spin_energy_calc
    import anneal_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       weight_we_i,
    input  spin_addr_t weight_addr_i,
    input  weight_t    weight_i,
    input  logic       cand_valid_i,
    input  spin_t      cand_spin_i,
    input  logic       calc_ready_i,
    output logic       cand_ready_o,
    output logic       calc_valid_o,
    output spin_t      calc_spin_o,
    output energy_t    calc_energy_o
);

    weight_t     weight_mem [`NUM_SPIN];
    calc_state_t state_q;
    calc_state_t state_next;
    logic        cand_ready_q;
    logic        cand_xfer;
    energy_t     energy_sum;
    spin_t       calc_spin_q;
    energy_t     calc_energy_q;

    // Field weight table, written one entry at a time by the strobe
    always_ff @(posedge clk_i) begin
        if (weight_we_i) begin
            weight_mem[weight_addr_i] <= weight_i;
        end
    end

    // A set spin lowers the energy by its weight and a clear spin raises it
    always_comb begin
        energy_sum = '0;
        for (int i = 0; i < `NUM_SPIN; i++) begin
            if (cand_spin_i[i]) begin
                energy_sum = energy_sum - energy_t'(weight_mem[i]);
            end else begin
                energy_sum = energy_sum + energy_t'(weight_mem[i]);
            end
        end
    end

    assign cand_xfer = cand_valid_i & cand_ready_q;

    // One candidate is held at a time until the maintainer takes it
    always_comb begin
        state_next = state_q;
        case (state_q)
            CALC_IDLE: if (cand_xfer) state_next = CALC_HOLD;
            CALC_HOLD: if (calc_ready_i) state_next = CALC_IDLE;
            default:   state_next = CALC_IDLE;
        endcase
        if (flush_i) begin
            state_next = CALC_IDLE;
        end
    end

    // Ready is registered so it stays low through reset and rises one edge later
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= CALC_IDLE;
            cand_ready_q <= 1'b0;
        end else begin
            state_q      <= state_next;
            cand_ready_q <= (state_next == CALC_IDLE);
        end
    end

    // Candidate and its energy are captured together on the accept edge
    always_ff @(posedge clk_i) begin
        if (cand_xfer) begin
            calc_spin_q   <= cand_spin_i;
            calc_energy_q <= energy_sum;
        end
    end

    assign cand_ready_o  = cand_ready_q;
    assign calc_valid_o  = (state_q == CALC_HOLD);
    assign calc_spin_o   = calc_spin_q;
    assign calc_energy_o = calc_energy_q;

endmodule

/* design/energy_fifo_maintainer.sv */
`timescale 1ns/1ns

module energy_fifo_maintainer
    import anneal_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    en_i,
    input  logic    flush_i,
    input  logic    en_comparison_i,
    input  logic    energy_valid_i,
    input  spin_t   spin_i,
    input  energy_t energy_i,
    input  logic    spin_ready_i,
    output logic    energy_ready_o,
    output logic    spin_valid_o,
    output spin_t   spin_o,
    output logic    spin_push_none_o,
    output energy_t best_energy_o,
    output usage_t  fifo_usage_o
);

    logic    fifo_full;
    energy_t fifo_head;
    logic    pipe_ready;
    logic    pipe_valid_in;
    logic    energy_xfer;
    logic    spin_xfer;
    logic    push_none_comb;
    logic    push_none_q;

    // The FIFO head is the best energy seen so far
    energy_fifo energy_fifo_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .push_i      (energy_xfer),
        .push_none_i (push_none_comb),
        .pop_i       (spin_xfer),
        .data_i      (energy_i),
        .full_o      (fifo_full),
        .data_o      (fifo_head),
        .usage_o     (fifo_usage_o)
    );

    // A pending candidate keeps the FIFO full, which stalls the next compare
    // until the running best has moved to the head
    assign pipe_valid_in  = energy_valid_i & en_i & ~fifo_full;
    assign energy_ready_o = en_i & ~fifo_full & pipe_ready;
    assign energy_xfer    = energy_valid_i & energy_ready_o;
    assign spin_xfer      = spin_valid_o & spin_ready_i;

    // Equal energies are not an improvement; comparison off forces one
    assign push_none_comb = en_comparison_i & (energy_i >= fifo_head);

    // Flag travels with the spin that is loaded into the pipe on the same edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            push_none_q <= 1'b0;
        end else if (flush_i) begin
            push_none_q <= 1'b0;
        end else if (energy_xfer) begin
            push_none_q <= push_none_comb;
        end
    end

    spin_pipe spin_pipe_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (pipe_valid_in),
        .data_i  (spin_i),
        .ready_i (spin_ready_i),
        .ready_o (pipe_ready),
        .valid_o (spin_valid_o),
        .data_o  (spin_o)
    );

    assign spin_push_none_o = push_none_q;
    assign best_energy_o    = fifo_head;

endmodule

/* design/best_spin_tracker.sv */
`timescale 1ns/1ns

module best_spin_tracker
    import anneal_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   out_ready_i,
    input  logic   spin_valid_i,
    input  spin_t  spin_i,
    input  logic   push_none_i,
    output logic   spin_ready_o,
    output spin_t  best_spin_o,
    output count_t improve_count_o
);

    logic   spin_xfer;
    logic   improve;
    spin_t  best_spin_q;
    count_t improve_count_q;

    // Back-pressure comes straight from the external sink
    assign spin_ready_o = out_ready_i;

    assign spin_xfer = spin_valid_i & out_ready_i;

    // Only transfers that carry an improvement touch the stored state
    assign improve = spin_xfer & ~push_none_i;

    // Best spin vector, starts from all zeros
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            best_spin_q <= '0;
        end else if (improve) begin
            best_spin_q <= spin_i;
        end
    end

    // Counter stops at its maximum rather than wrapping back to zero
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            improve_count_q <= '0;
        end else if (improve && (improve_count_q != '1)) begin
            improve_count_q <= improve_count_q + 1'b1;
        end
    end

    assign best_spin_o     = best_spin_q;
    assign improve_count_o = improve_count_q;

endmodule

/* design/anneal_top.sv */
`timescale 1ns/1ns

module anneal_top
    import anneal_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       en_i,
    input  logic       en_comparison_i,
    input  logic       weight_we_i,
    input  spin_addr_t weight_addr_i,
    input  weight_t    weight_i,
    input  logic       cand_valid_i,
    input  spin_t      cand_spin_i,
    output logic       cand_ready_o,
    input  logic       out_ready_i,
    output spin_t      best_spin_o,
    output energy_t    best_energy_o,
    output count_t     improve_count_o,
    output usage_t     fifo_usage_o
);

    // Input stage to maintainer
    logic    calc_valid;
    spin_t   calc_spin;
    energy_t calc_energy;
    logic    calc_ready;

    // Maintainer to tracker
    logic    fwd_valid;
    spin_t   fwd_spin;
    logic    fwd_push_none;
    logic    fwd_ready;

    spin_energy_calc spin_energy_calc_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .weight_we_i   (weight_we_i),
        .weight_addr_i (weight_addr_i),
        .weight_i      (weight_i),
        .cand_valid_i  (cand_valid_i),
        .cand_spin_i   (cand_spin_i),
        .calc_ready_i  (calc_ready),
        .cand_ready_o  (cand_ready_o),
        .calc_valid_o  (calc_valid),
        .calc_spin_o   (calc_spin),
        .calc_energy_o (calc_energy)
    );

    // The tracker has no flush, so the best spin and count survive one
    energy_fifo_maintainer energy_fifo_maintainer_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .en_i             (en_i),
        .flush_i          (flush_i),
        .en_comparison_i  (en_comparison_i),
        .energy_valid_i   (calc_valid),
        .spin_i           (calc_spin),
        .energy_i         (calc_energy),
        .spin_ready_i     (fwd_ready),
        .energy_ready_o   (calc_ready),
        .spin_valid_o     (fwd_valid),
        .spin_o           (fwd_spin),
        .spin_push_none_o (fwd_push_none),
        .best_energy_o    (best_energy_o),
        .fifo_usage_o     (fifo_usage_o)
    );

    best_spin_tracker best_spin_tracker_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .out_ready_i     (out_ready_i),
        .spin_valid_i    (fwd_valid),
        .spin_i          (fwd_spin),
        .push_none_i     (fwd_push_none),
        .spin_ready_o    (fwd_ready),
        .best_spin_o     (best_spin_o),
        .improve_count_o (improve_count_o)
    );

endmodule

/* test/anneal_sva.sv */
`timescale 1ns/1ns

`include "anneal_cfg.svh"

module anneal_sva
    import anneal_pkg::*;
(
    input logic    clk_i,
    input logic    rst_n_i,
    input logic    flush_i,
    input logic    cand_ready_i,
    input logic    calc_valid_i,
    input logic    calc_ready_i,
    input spin_t   calc_spin_i,
    input energy_t calc_energy_i,
    input logic    fwd_valid_i,
    input logic    fwd_ready_i,
    input spin_t   fwd_spin_i,
    input logic    fwd_push_none_i,
    input usage_t  fifo_usage_i
);

    // A candidate stalled at the maintainer input keeps its valid and its payload
    // A flush in the stall cycle is allowed to drop it
    calc_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !flush_i && calc_valid_i && !calc_ready_i |=>
            calc_valid_i && $stable(calc_spin_i) && $stable(calc_energy_i))
    else $error("calc stage dropped or changed a stalled candidate");

    // Same rule on the forward side where the flag travels with its spin
    fwd_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !flush_i && fwd_valid_i && !fwd_ready_i |=>
            fwd_valid_i && $stable(fwd_spin_i) && $stable(fwd_push_none_i))
    else $error("forward stage dropped or changed a stalled spin");

    // Occupancy is bounded by the FIFO depth
    usage_max_a: assert property (@(posedge clk_i)
        fifo_usage_i <= usage_t'(`ENERGY_FIFO_DEPTH))
    else $error("energy FIFO usage went above its depth");

    // No candidate may be accepted while reset is held
    reset_ready_a: assert property (@(posedge clk_i)
        !rst_n_i |-> !cand_ready_i)
    else $error("cand_ready_o was high during reset");

endmodule

/* test/anneal_tb.sv */
`timescale 1ns/1ns

`include "anneal_cfg.svh"

module anneal_tb
    import anneal_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_IMPROVE  = 8;
    localparam int NUM_MIXED    = 12;
    localparam int MAX_STALL    = 6;
    localparam int WAIT_LIMIT   = 20;
    // A candidate without stall needs about six cycles from drive to tracker update
    localparam int CAND_CYCLES  = 8;
    localparam int NUM_CAND     = NUM_IMPROVE + NUM_MIXED + 14;
    localparam int TEST_CYCLES  = RESET_CYCLES + `NUM_SPIN
                                + NUM_CAND * (CAND_CYCLES + MAX_STALL) + 100;
    localparam energy_t INIT_ENERGY = `ENERGY_INIT;

    logic       clk_i;
    logic       rst_n_i;
    logic       flush_i;
    logic       en_i;
    logic       en_comparison_i;
    logic       weight_we_i;
    spin_addr_t weight_addr_i;
    weight_t    weight_i;
    logic       cand_valid_i;
    spin_t      cand_spin_i;
    logic       cand_ready_o;
    logic       out_ready_i;
    spin_t      best_spin_o;
    energy_t    best_energy_o;
    count_t     improve_count_o;
    usage_t     fifo_usage_o;

    // Reference state kept next to the DUT
    weight_t model_weight [`NUM_SPIN];
    energy_t model_best;
    spin_t   model_spin;
    count_t  model_count;

    anneal_top anneal_top_i (.*);

    bind anneal_top anneal_sva anneal_sva_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .cand_ready_i    (cand_ready_o),
        .calc_valid_i    (calc_valid),
        .calc_ready_i    (calc_ready),
        .calc_spin_i     (calc_spin),
        .calc_energy_i   (calc_energy),
        .fwd_valid_i     (fwd_valid),
        .fwd_ready_i     (fwd_ready),
        .fwd_spin_i      (fwd_spin),
        .fwd_push_none_i (fwd_push_none),
        .fifo_usage_i    (fifo_usage_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Watchdog sized from the number of candidates and their worst stall
    initial begin
        #(CLK_PERIOD * TEST_CYCLES);
        $display("Watchdog expired at %0t ns, the tests did not finish", $time);
        abort_run();
    end

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Every task returns 1 ns after a rising edge, where inputs are driven
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    // Energy is the weight sum with every set spin subtracted twice
    function automatic energy_t energy_of(input spin_t spin);
        int total;
        total = 0;
        for (int i = 0; i < `NUM_SPIN; i++) begin
            total += int'(model_weight[i]);
            if (spin[i]) begin
                total -= 2 * int'(model_weight[i]);
            end
        end
        return energy_t'(total);
    endfunction

    // Every spin on the side that raises the energy
    function automatic spin_t worst_spin();
        spin_t spin;
        for (int i = 0; i < `NUM_SPIN; i++) begin
            spin[i] = (model_weight[i] < 0);
        end
        return spin;
    endfunction

    function automatic void update_model(input spin_t spin);
        energy_t energy;
        energy = energy_of(spin);
        if (!en_comparison_i || energy < model_best) begin
            model_best = energy;
            model_spin = spin;
            if (model_count != '1) begin
                model_count = model_count + 1'b1;
            end
        end
    endfunction

    task automatic check_model();
        check(32'(best_spin_o), 32'(model_spin), "best spin");
        check(32'(best_energy_o), 32'(model_best), "best energy");
        check(32'(improve_count_o), 32'(model_count), "improvement count");
        check(32'(fifo_usage_o), 32'd1, "FIFO usage when idle");
    endtask

    // Nonzero weights of random sign, so every spin moves the energy
    task automatic load_weights();
        int magnitude;
        for (int i = 0; i < `NUM_SPIN; i++) begin
            magnitude = $urandom_range(60, 1);
            if ($urandom_range(1, 0) == 1) begin
                magnitude = -magnitude;
            end
            model_weight[i] = weight_t'(magnitude);
            weight_we_i     = 1'b1;
            weight_addr_i   = spin_addr_t'(i);
            weight_i        = model_weight[i];
            wait_cycles(1);
        end
        weight_we_i = 1'b0;
    endtask

    // Holds the candidate until cand_ready_o is seen high at a falling edge
    task automatic send_candidate(input spin_t spin);
        int waited;
        waited       = 0;
        cand_valid_i = 1'b1;
        cand_spin_i  = spin;
        @(negedge clk_i);
        while (!cand_ready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timed out at %0t ns waiting for cand_ready_o", $time);
                abort_run();
            end
            @(negedge clk_i);
        end
        wait_cycles(1);
        cand_valid_i = 1'b0;
    endtask

    // Usage goes to 2 at the maintainer accept and back to 1 at the tracker transfer
    task automatic wait_usage(input usage_t target);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (fifo_usage_o != target) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timed out at %0t ns waiting for FIFO usage %0d", $time, target);
                abort_run();
            end
            @(negedge clk_i);
        end
        wait_cycles(1);
    endtask

    task automatic run_candidate(input spin_t spin, input int stall);
        if (stall > 0) begin
            out_ready_i = 1'b0;
        end
        send_candidate(spin);
        wait_usage(2'd2);
        if (stall > 0) begin
            wait_cycles(stall);
            check(32'(fifo_usage_o), 32'd2, "FIFO usage under back-pressure");
            check(32'(improve_count_o), 32'(model_count), "count under back-pressure");
            out_ready_i = 1'b1;
        end
        wait_usage(2'd1);
        update_model(spin);
        check_model();
    endtask

    task automatic test_reset_state();
        check(32'(best_spin_o), 32'd0, "best spin after reset");
        check(32'(improve_count_o), 32'd0, "count after reset");
        check(32'(fifo_usage_o), 32'd1, "FIFO usage after reset");
        check(32'(best_energy_o), 32'(INIT_ENERGY), "best energy after reset");
        check(32'(cand_ready_o), 32'd0, "cand_ready_o before the first edge");
    endtask

    // Flipping one spin at a time to its low side lowers the energy strictly
    task automatic test_improving();
        spin_t  spin;
        count_t count_before;
        load_weights();
        spin = worst_spin();
        for (int flip = 0; flip <= NUM_IMPROVE; flip++) begin
            if (flip > 0) begin
                spin[flip - 1] = ~spin[flip - 1];
            end
            count_before = model_count;
            run_candidate(spin, 0);
            check(32'(improve_count_o), 32'(count_before) + 32'd1, "count after improvement");
            check(32'(best_spin_o), 32'(spin), "best spin after improvement");
            check(32'(best_energy_o), 32'(energy_of(spin)), "best energy after improvement");
        end
    endtask

    // Equal to the best, the worst, and one flip away from the worst
    task automatic test_no_improvement();
        spin_t   cands [3];
        spin_t   spin_before;
        energy_t energy_before;
        count_t  count_before;
        spin_before   = model_spin;
        energy_before = model_best;
        count_before  = model_count;
        cands[0] = spin_before;
        cands[1] = worst_spin();
        cands[2] = worst_spin() ^ spin_t'(1);
        foreach (cands[k]) begin
            run_candidate(cands[k], 0);
            check(32'(best_spin_o), 32'(spin_before), "best spin after no improvement");
            check(32'(improve_count_o), 32'(count_before), "count after no improvement");
            check(32'(best_energy_o), 32'(energy_before), "best energy after no improvement");
        end
    endtask

    task automatic test_back_pressure();
        for (int n = 0; n < NUM_MIXED; n++) begin
            run_candidate(spin_t'($urandom), $urandom_range(MAX_STALL, 1));
        end
        check_model();
    endtask

    // The lowest possible energy first, then the highest, which still wins
    task automatic test_comparison_off();
        spin_t cands [4];
        cands[0] = ~worst_spin();
        cands[1] = worst_spin();
        cands[2] = spin_t'($urandom);
        cands[3] = spin_t'($urandom);
        en_comparison_i = 1'b0;
        foreach (cands[k]) begin
            run_candidate(cands[k], 0);
            check(32'(best_energy_o), 32'(energy_of(cands[k])), "energy, comparison off");
            check(32'(best_spin_o), 32'(cands[k]), "best spin, comparison off");
        end
        en_comparison_i = 1'b1;
    endtask

    task automatic test_flush_and_enable();
        spin_t  spin;
        spin_t  spin_before;
        count_t count_before;
        // The lowest energy stuck behind a stalled sink would win, so the flush has to drop it
        spin         = ~worst_spin();
        spin_before  = model_spin;
        count_before = model_count;
        out_ready_i  = 1'b0;
        send_candidate(spin);
        wait_usage(2'd2);
        flush_i = 1'b1;
        wait_cycles(1);
        flush_i    = 1'b0;
        model_best = INIT_ENERGY;
        check(32'(fifo_usage_o), 32'd1, "FIFO usage after flush");
        check(32'(best_energy_o), 32'(INIT_ENERGY), "best energy after flush");
        out_ready_i = 1'b1;
        wait_cycles(3);
        check(32'(best_spin_o), 32'(spin_before), "best spin kept over flush");
        check(32'(improve_count_o), 32'(count_before), "count kept over flush");
        // The seed energy is back at the head, so the next candidate improves
        run_candidate(spin_t'($urandom), 0);
        // With the maintainer disabled the input stage takes one candidate and stalls
        spin            = spin_t'($urandom);
        count_before    = model_count;
        en_i            = 1'b0;
        cand_valid_i    = 1'b1;
        cand_spin_i     = spin;
        wait_cycles(2);
        check(32'(cand_ready_o), 32'd0, "cand_ready_o with en_i low");
        check(32'(fifo_usage_o), 32'd1, "FIFO usage with en_i low");
        // Long enough for an enabled maintainer to have reached the tracker
        wait_cycles(2);
        check(32'(improve_count_o), 32'(count_before), "count with en_i low");
        cand_valid_i = 1'b0;
        en_i         = 1'b1;
        wait_usage(2'd2);
        wait_usage(2'd1);
        update_model(spin);
        check_model();
    endtask

    initial begin
        void'($urandom(474));
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        en_i            = 1'b1;
        en_comparison_i = 1'b1;
        weight_we_i     = 1'b0;
        weight_addr_i   = '0;
        weight_i        = '0;
        cand_valid_i    = 1'b0;
        cand_spin_i     = '0;
        out_ready_i     = 1'b1;
        model_best      = INIT_ENERGY;
        model_spin      = '0;
        model_count     = '0;
        wait_cycles(RESET_CYCLES);
        rst_n_i = 1'b1;
        test_reset_state();
        test_improving();
        test_no_improvement();
        test_back_pressure();
        test_comparison_off();
        test_flush_and_enable();
        $display("Test OK");
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/anneal_pkg.sv
design/energy_fifo.sv
design/spin_pipe.sv
design/spin_energy_calc.sv
design/energy_fifo_maintainer.sv
design/best_spin_tracker.sv
design/anneal_top.sv
test/anneal_sva.sv
test/anneal_tb.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := anneal_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test OK

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
